/* src/lc4_pkg.sv */
package lc4_pkg;

    // datapath and register file sizes
    localparam int XLEN      = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;
    localparam int NUM_LANES = 2;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 16'h8200;

    // instruction bits 15:12
    typedef enum logic [3:0] {
        OP_NOP   = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_CONST = 4'b1001
    } opcode_e;

    // ALU function, picked from opcode and sub-op bits
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM
    } alu_op_e;

    // decoded instruction as it travels down a lane
    typedef struct packed {
        logic [XLEN-1:0]      pc;
        alu_op_e              alu_op;
        logic [REG_SEL_W-1:0] rd;
        logic [REG_SEL_W-1:0] rs;
        logic [REG_SEL_W-1:0] rt;
        logic                 rs_re;
        logic                 rt_re;
        logic                 use_imm;
        logic [XLEN-1:0]      imm;
        logic                 rd_we;
    } uop_t;

endpackage

/* src/issue_if.sv */
// one issued instruction plus the operands read for it in D
interface issue_if;
    logic                      valid;
    lc4_pkg::uop_t             uop;
    logic [lc4_pkg::XLEN-1:0]  rs_data;
    logic [lc4_pkg::XLEN-1:0]  rt_data;

    modport issue (
        output valid,
        output uop,
        output rs_data,
        output rt_data
    );

    modport lane (
        input valid,
        input uop,
        input rs_data,
        input rt_data
    );
endinterface

/* src/wb_if.sv */
// one lane's W-stage result, also used as a bypass source
interface wb_if;
    logic                           we;
    logic [lc4_pkg::REG_SEL_W-1:0]  wsel;
    logic [lc4_pkg::XLEN-1:0]       data;
    logic [lc4_pkg::XLEN-1:0]       pc;

    modport lane (
        output we,
        output wsel,
        output data,
        output pc
    );

    modport sink (
        input we,
        input wsel,
        input data,
        input pc
    );
endinterface

/* src/issue_unit.sv */
module issue_unit (
    input  logic                           gwe,
    input  logic                           i_reset,
    input  logic [lc4_pkg::XLEN-1:0]       i_insn_a,
    input  logic [lc4_pkg::XLEN-1:0]       i_insn_b,
    output logic [lc4_pkg::XLEN-1:0]       o_cur_pc,
    output logic [lc4_pkg::REG_SEL_W-1:0]  o_rs_sel [lc4_pkg::NUM_LANES],
    output logic [lc4_pkg::REG_SEL_W-1:0]  o_rt_sel [lc4_pkg::NUM_LANES],
    input  logic [lc4_pkg::XLEN-1:0]       i_rs_data [lc4_pkg::NUM_LANES],
    input  logic [lc4_pkg::XLEN-1:0]       i_rt_data [lc4_pkg::NUM_LANES],
    issue_if.issue                         o_issue [lc4_pkg::NUM_LANES]
);

    logic [lc4_pkg::XLEN-1:0]      pc;
    logic [lc4_pkg::XLEN-1:0]      pc_inc1;
    lc4_pkg::uop_t                 f_uop_a;
    lc4_pkg::uop_t                 f_uop_b;
    logic                          pair_hazard;
    logic [lc4_pkg::XLEN-1:0]      d_pc [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::XLEN-1:0]      d_insn [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::NUM_LANES-1:0] d_valid;
    lc4_pkg::uop_t                 d_uop [lc4_pkg::NUM_LANES];

    // LC4 subset decode; anything unrecognised becomes a NOP
    function automatic lc4_pkg::uop_t decode(input logic [lc4_pkg::XLEN-1:0] insn,
                                             input logic [lc4_pkg::XLEN-1:0] insn_pc);
        lc4_pkg::uop_t    u;
        lc4_pkg::opcode_e op;
        u = '0;
        op = lc4_pkg::opcode_e'(insn[15:12]);
        u.pc = insn_pc;
        u.rd = insn[11:9];
        u.rs = insn[8:6];
        u.rt = insn[2:0];
        u.imm = {{(lc4_pkg::XLEN-5){insn[4]}}, insn[4:0]};
        u.alu_op = lc4_pkg::ALU_ADD;
        case (op)
            lc4_pkg::OP_ARITH, lc4_pkg::OP_LOGIC: begin
                u.rs_re = 1'b1;
                u.rd_we = 1'b1;
                if (insn[5]) begin
                    u.use_imm = 1'b1;
                    u.alu_op = (op == lc4_pkg::OP_ARITH) ? lc4_pkg::ALU_ADD : lc4_pkg::ALU_AND;
                end else begin
                    u.rt_re = 1'b1;
                    case ({op == lc4_pkg::OP_LOGIC, insn[5:3]})
                        4'b0_000: u.alu_op = lc4_pkg::ALU_ADD;
                        4'b0_010: u.alu_op = lc4_pkg::ALU_SUB;
                        4'b1_000: u.alu_op = lc4_pkg::ALU_AND;
                        4'b1_010: u.alu_op = lc4_pkg::ALU_OR;
                        4'b1_011: u.alu_op = lc4_pkg::ALU_XOR;
                        default: begin
                            // undefined sub-op
                            u.rs_re = 1'b0;
                            u.rt_re = 1'b0;
                            u.rd_we = 1'b0;
                        end
                    endcase
                end
            end
            lc4_pkg::OP_CONST: begin
                u.use_imm = 1'b1;
                u.rd_we = 1'b1;
                u.imm = {{(lc4_pkg::XLEN-9){insn[8]}}, insn[8:0]};
                u.alu_op = lc4_pkg::ALU_PASS_IMM;
            end
            default: begin
                u.alu_op = lc4_pkg::ALU_ADD;
            end
        endcase
        return u;
    endfunction

    assign pc_inc1 = pc + lc4_pkg::XLEN'(1);
    assign o_cur_pc = pc;

    // pairing check on the fetched slots
    assign f_uop_a = decode(i_insn_a, pc);
    assign f_uop_b = decode(i_insn_b, pc_inc1);
    assign pair_hazard = f_uop_a.rd_we &&
                         ((f_uop_b.rs_re && (f_uop_b.rs == f_uop_a.rd)) ||
                          (f_uop_b.rt_re && (f_uop_b.rt == f_uop_a.rd)));

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc <= lc4_pkg::RESET_PC;
            d_valid <= '0;
        end else begin
            // a held-back B comes round again as next cycle's A
            pc <= pc + (pair_hazard ? lc4_pkg::XLEN'(1) : lc4_pkg::XLEN'(2));
            d_valid <= {~pair_hazard, 1'b1};
        end
    end

    always_ff @(posedge gwe) begin
        d_pc[0] <= pc;
        d_pc[1] <= pc_inc1;
        d_insn[0] <= i_insn_a;
        d_insn[1] <= i_insn_b;
    end

    for (genvar l = 0; l < lc4_pkg::NUM_LANES; l++) begin : g_slot
        assign d_uop[l] = decode(d_insn[l], d_pc[l]);
        assign o_rs_sel[l] = d_uop[l].rs;
        assign o_rt_sel[l] = d_uop[l].rt;
        assign o_issue[l].valid = d_valid[l];
        assign o_issue[l].uop = d_uop[l];
        assign o_issue[l].rs_data = i_rs_data[l];
        assign o_issue[l].rt_data = i_rt_data[l];
    end

endmodule

/* src/exec_lane.sv */
module exec_lane (
    input  logic   gwe,
    input  logic   i_reset,
    issue_if.lane  i_issue,
    wb_if.lane     o_wb,
    wb_if.sink     i_wb_src [lc4_pkg::NUM_LANES]
);

    logic                           x_valid;
    lc4_pkg::uop_t                  x_uop;
    logic [lc4_pkg::XLEN-1:0]       x_rs_data;
    logic [lc4_pkg::XLEN-1:0]       x_rt_data;
    logic                           src_we [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::REG_SEL_W-1:0]  src_wsel [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::XLEN-1:0]       src_data [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::XLEN-1:0]       rs_val;
    logic [lc4_pkg::XLEN-1:0]       rt_val;
    logic [lc4_pkg::XLEN-1:0]       op_b;
    logic [lc4_pkg::XLEN-1:0]       alu_result;
    logic                           w_we;
    logic [lc4_pkg::REG_SEL_W-1:0]  w_wsel;
    logic [lc4_pkg::XLEN-1:0]       w_data;
    logic [lc4_pkg::XLEN-1:0]       w_pc;

    // X stage
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= i_issue.valid;
        end
    end

    always_ff @(posedge gwe) begin
        x_uop <= i_issue.uop;
        x_rs_data <= i_issue.rs_data;
        x_rt_data <= i_issue.rt_data;
    end

    for (genvar s = 0; s < lc4_pkg::NUM_LANES; s++) begin : g_src
        assign src_we[s] = i_wb_src[s].we;
        assign src_wsel[s] = i_wb_src[s].wsel;
        assign src_data[s] = i_wb_src[s].data;
    end

    // WX bypass, lane 1 is the younger writer so it is applied last
    always_comb begin
        rs_val = x_rs_data;
        rt_val = x_rt_data;
        for (int s = 0; s < lc4_pkg::NUM_LANES; s++) begin
            if (src_we[s] && (src_wsel[s] == x_uop.rs)) begin
                rs_val = src_data[s];
            end
            if (src_we[s] && (src_wsel[s] == x_uop.rt)) begin
                rt_val = src_data[s];
            end
        end
    end

    assign op_b = x_uop.use_imm ? x_uop.imm : rt_val;

    always_comb begin
        case (x_uop.alu_op)
            lc4_pkg::ALU_ADD:      alu_result = rs_val + op_b;
            lc4_pkg::ALU_SUB:      alu_result = rs_val - op_b;
            lc4_pkg::ALU_AND:      alu_result = rs_val & op_b;
            lc4_pkg::ALU_OR:       alu_result = rs_val | op_b;
            lc4_pkg::ALU_XOR:      alu_result = rs_val ^ op_b;
            lc4_pkg::ALU_PASS_IMM: alu_result = x_uop.imm;
            default:               alu_result = '0;
        endcase
    end

    // W stage
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            w_we <= 1'b0;
        end else begin
            w_we <= x_valid && x_uop.rd_we;
        end
    end

    always_ff @(posedge gwe) begin
        w_wsel <= x_uop.rd;
        w_data <= alu_result;
        w_pc <= x_uop.pc;
    end

    assign o_wb.we = w_we;
    assign o_wb.wsel = w_wsel;
    assign o_wb.data = w_data;
    assign o_wb.pc = w_pc;

endmodule

/* src/regfile_2w.sv */
module regfile_2w (
    input  logic                           gwe,
    input  logic                           i_reset,
    wb_if.sink                             i_wb [lc4_pkg::NUM_LANES],
    input  logic [lc4_pkg::REG_SEL_W-1:0]  i_rs_sel [lc4_pkg::NUM_LANES],
    input  logic [lc4_pkg::REG_SEL_W-1:0]  i_rt_sel [lc4_pkg::NUM_LANES],
    output logic [lc4_pkg::XLEN-1:0]       o_rs_data [lc4_pkg::NUM_LANES],
    output logic [lc4_pkg::XLEN-1:0]       o_rt_data [lc4_pkg::NUM_LANES]
);

    logic [lc4_pkg::XLEN-1:0]       regs [lc4_pkg::NUM_REGS];
    logic                           wb_we [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::REG_SEL_W-1:0]  wb_wsel [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::XLEN-1:0]       wb_data [lc4_pkg::NUM_LANES];

    for (genvar w = 0; w < lc4_pkg::NUM_LANES; w++) begin : g_wb
        assign wb_we[w] = i_wb[w].we;
        assign wb_wsel[w] = i_wb[w].wsel;
        assign wb_data[w] = i_wb[w].data;
    end

    // lane 1 written after lane 0, so it wins on a clash
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int r = 0; r < lc4_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < lc4_pkg::NUM_LANES; w++) begin
                if (wb_we[w]) begin
                    regs[wb_wsel[w]] <= wb_data[w];
                end
            end
        end
    end

    // reads see this cycle's writebacks
    always_comb begin
        for (int l = 0; l < lc4_pkg::NUM_LANES; l++) begin
            o_rs_data[l] = regs[i_rs_sel[l]];
            o_rt_data[l] = regs[i_rt_sel[l]];
            for (int w = 0; w < lc4_pkg::NUM_LANES; w++) begin
                if (wb_we[w] && (wb_wsel[w] == i_rs_sel[l])) begin
                    o_rs_data[l] = wb_data[w];
                end
                if (wb_we[w] && (wb_wsel[w] == i_rt_sel[l])) begin
                    o_rt_data[l] = wb_data[w];
                end
            end
        end
    end

endmodule

/* src/lc4_dual_top.sv */
module lc4_dual_top (
    input  logic                           gwe,
    input  logic                           i_reset,
    input  logic [lc4_pkg::XLEN-1:0]       i_insn_a,
    input  logic [lc4_pkg::XLEN-1:0]       i_insn_b,
    output logic [lc4_pkg::XLEN-1:0]       o_cur_pc,
    output logic                           o_wb_we_a,
    output logic [lc4_pkg::REG_SEL_W-1:0]  o_wb_wsel_a,
    output logic [lc4_pkg::XLEN-1:0]       o_wb_data_a,
    output logic [lc4_pkg::XLEN-1:0]       o_wb_pc_a,
    output logic                           o_wb_we_b,
    output logic [lc4_pkg::REG_SEL_W-1:0]  o_wb_wsel_b,
    output logic [lc4_pkg::XLEN-1:0]       o_wb_data_b,
    output logic [lc4_pkg::XLEN-1:0]       o_wb_pc_b
);

    logic [lc4_pkg::REG_SEL_W-1:0]  rs_sel [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::REG_SEL_W-1:0]  rt_sel [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::XLEN-1:0]       rs_data [lc4_pkg::NUM_LANES];
    logic [lc4_pkg::XLEN-1:0]       rt_data [lc4_pkg::NUM_LANES];

    issue_if iss [lc4_pkg::NUM_LANES] ();
    wb_if    wb  [lc4_pkg::NUM_LANES] ();

    issue_unit u_issue (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_insn_a  (i_insn_a),
        .i_insn_b  (i_insn_b),
        .o_cur_pc  (o_cur_pc),
        .o_rs_sel  (rs_sel),
        .o_rt_sel  (rt_sel),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_issue   (iss)
    );

    // slot A runs in lane 0, slot B in lane 1
    for (genvar g = 0; g < lc4_pkg::NUM_LANES; g++) begin : g_lane
        exec_lane u_lane (
            .gwe      (gwe),
            .i_reset  (i_reset),
            .i_issue  (iss[g]),
            .o_wb     (wb[g]),
            .i_wb_src (wb)
        );
    end

    regfile_2w u_regfile (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_wb      (wb),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // writeback trace
    assign o_wb_we_a = wb[0].we;
    assign o_wb_wsel_a = wb[0].wsel;
    assign o_wb_data_a = wb[0].data;
    assign o_wb_pc_a = wb[0].pc;
    assign o_wb_we_b = wb[1].we;
    assign o_wb_wsel_b = wb[1].wsel;
    assign o_wb_data_b = wb[1].data;
    assign o_wb_pc_b = wb[1].pc;

endmodule

/* sim/lc4_ref_model.svh */
`ifndef LC4_REF_MODEL_SVH
`define LC4_REF_MODEL_SVH

localparam int PROG_MAX = 64;

// one register write as the in-order model sees it
typedef struct packed {
    logic [2:0]  wsel;
    logic [15:0] data;
    logic [15:0] pc;
} reg_write_t;

// instruction memory, word 0 sits at the reset PC
logic [15:0] prog_mem [PROG_MAX];
int          prog_len;
reg_write_t  exp_q [$];

function automatic void clear_program();
    prog_len = 0;
    for (int i = 0; i < PROG_MAX; i++) begin
        prog_mem[i] = '0;
    end
endfunction

function automatic void add_insn(input logic [15:0] insn);
    if (prog_len < PROG_MAX) begin
        prog_mem[prog_len] = insn;
        prog_len++;
    end
endfunction

function automatic logic [15:0] enc_rrr(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] sub,
                                        input logic [2:0] rt);
    return {op, rd, rs, sub, rt};
endfunction

function automatic logic [15:0] enc_rri(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [4:0] imm);
    return {op, rd, rs, 1'b1, imm};
endfunction

function automatic logic [15:0] enc_const(input logic [2:0] rd, input logic [8:0] imm);
    return {4'b1001, rd, imm};
endfunction

// words past the end of the program are NOPs
function automatic logic [15:0] fetch_word(input logic [15:0] pc);
    int idx;
    idx = int'(pc - lc4_pkg::RESET_PC);
    if (idx >= 0 && idx < prog_len) begin
        return prog_mem[idx];
    end
    return '0;
endfunction

// LC4 subset semantics; a and b are the rs and rt values
function automatic void model_insn(input logic [15:0] insn, input logic [15:0] a,
                                   input logic [15:0] b, output logic wr,
                                   output logic use_rs, output logic use_rt,
                                   output logic [15:0] res);
    logic [15:0] imm5;
    imm5 = {{11{insn[4]}}, insn[4:0]};
    wr = 1'b1;
    use_rs = 1'b1;
    use_rt = !insn[5];
    res = '0;
    if (insn[15:12] == 4'b1001) begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        res = {{7{insn[8]}}, insn[8:0]};
    end else if (insn[15:12] == 4'b0001 && insn[5]) begin
        res = a + imm5;
    end else if (insn[15:12] == 4'b0001 && insn[5:3] == 3'b000) begin
        res = a + b;
    end else if (insn[15:12] == 4'b0001 && insn[5:3] == 3'b010) begin
        res = a - b;
    end else if (insn[15:12] == 4'b0101 && insn[5]) begin
        res = a & imm5;
    end else if (insn[15:12] == 4'b0101 && insn[5:3] == 3'b000) begin
        res = a & b;
    end else if (insn[15:12] == 4'b0101 && insn[5:3] == 3'b010) begin
        res = a | b;
    end else if (insn[15:12] == 4'b0101 && insn[5:3] == 3'b011) begin
        res = a ^ b;
    end else begin
        wr = 1'b0;
        use_rs = 1'b0;
        use_rt = 1'b0;
    end
endfunction

// run the program one instruction at a time from a cleared register file
function automatic void build_expected();
    logic [15:0] regs [8];
    logic        wr;
    logic        use_rs;
    logic        use_rt;
    logic [15:0] res;
    logic [15:0] insn;
    exp_q.delete();
    for (int r = 0; r < 8; r++) begin
        regs[r] = '0;
    end
    for (int i = 0; i < prog_len; i++) begin
        insn = prog_mem[i];
        model_insn(insn, regs[insn[8:6]], regs[insn[2:0]], wr, use_rs, use_rt, res);
        if (wr) begin
            regs[insn[11:9]] = res;
            exp_q.push_back('{wsel: insn[11:9], data: res,
                              pc: lc4_pkg::RESET_PC + 16'(i)});
        end
    end
endfunction

`endif

/* sim/tb_lc4_dual.sv */
module tb_lc4_dual;
    timeunit 1ns;
    timeprecision 1ps;

    `include "lc4_ref_model.svh"

    localparam int LEN_RESET  = 4;
    localparam int LEN_INDEP  = 12;
    localparam int LEN_PAIR   = 6;
    localparam int LEN_CHAIN  = 10;
    localparam int LEN_RANDOM = 64;
    localparam int NUM_TESTS  = 5;
    localparam int CYCLE_LIMIT =
        2 * (LEN_RESET + LEN_INDEP + LEN_PAIR + LEN_CHAIN + LEN_RANDOM) + 20 * NUM_TESTS;

    logic        gwe = 1'b0;
    logic        i_reset;
    logic [15:0] i_insn_a;
    logic [15:0] i_insn_b;
    logic [15:0] o_cur_pc;
    logic        o_wb_we_a;
    logic [2:0]  o_wb_wsel_a;
    logic [15:0] o_wb_data_a;
    logic [15:0] o_wb_pc_a;
    logic        o_wb_we_b;
    logic [2:0]  o_wb_wsel_b;
    logic [15:0] o_wb_data_b;
    logic [15:0] o_wb_pc_b;

    int cycle_count = 0;
    int err_cnt = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int single_steps;
    int fetch_cycle [PROG_MAX + 2];

    lc4_dual_top UUT (
        .gwe         (gwe),
        .i_reset     (i_reset),
        .i_insn_a    (i_insn_a),
        .i_insn_b    (i_insn_b),
        .o_cur_pc    (o_cur_pc),
        .o_wb_we_a   (o_wb_we_a),
        .o_wb_wsel_a (o_wb_wsel_a),
        .o_wb_data_a (o_wb_data_a),
        .o_wb_pc_a   (o_wb_pc_a),
        .o_wb_we_b   (o_wb_we_b),
        .o_wb_wsel_b (o_wb_wsel_b),
        .o_wb_data_b (o_wb_data_b),
        .o_wb_pc_b   (o_wb_pc_b)
    );

    initial begin
        forever #5 gwe = ~gwe;
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge gwe);
            cycle_count++;
        end
        $display("run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic show_mismatch(input string sig, input logic [15:0] exp_val,
                                 input logic [15:0] act_val);
        $display("Error at %0t: %s expected %h, got %h", $time, sig, exp_val, act_val);
        err_cnt++;
    endtask

    // compare one lane's write against the next expected one
    task automatic check_write(input logic we, input logic [2:0] wsel, input logic [15:0] data,
                               input logic [15:0] pc, input int cyc, input string lane);
        reg_write_t exp;
        int         off;
        if (we) begin
            assert (exp_q.size() > 0) else begin
                $display("extra write on lane %s at %0t, pc %h", lane, $time, pc);
                err_cnt++;
            end
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                off = int'(exp.pc - lc4_pkg::RESET_PC);
                assert (wsel == exp.wsel) else
                    show_mismatch({"o_wb_wsel_", lane}, 16'(exp.wsel), 16'(wsel));
                assert (data == exp.data) else show_mismatch({"o_wb_data_", lane}, exp.data, data);
                assert (pc == exp.pc) else show_mismatch({"o_wb_pc_", lane}, exp.pc, pc);
                assert (cyc == fetch_cycle[off] + 3) else
                    show_mismatch({"write cycle of o_wb_pc_", lane},
                                  16'(fetch_cycle[off] + 3), 16'(cyc));
            end
        end
    endtask

    // reset, then feed the program from o_cur_pc until the pipeline drains
    task automatic run_program();
        logic [15:0] prev_pc;
        logic [15:0] dummy;
        logic        prev_hazard;
        logic        wr_a;
        logic        rs_a;
        logic        rt_a;
        logic        wr_b;
        logic        rs_b;
        logic        rt_b;
        int          cyc;
        int          drain;
        int          off;
        build_expected();
        single_steps = 0;
        cyc = 0;
        drain = 0;
        prev_pc = '0;
        prev_hazard = 1'b0;
        i_reset = 1'b1;
        i_insn_a = '0;
        i_insn_b = '0;
        repeat (2) @(negedge gwe);
        i_reset = 1'b0;
        while (drain < 5) begin
            off = int'(o_cur_pc - lc4_pkg::RESET_PC);
            if (cyc == 0) begin
                assert (o_cur_pc == lc4_pkg::RESET_PC) else
                    show_mismatch("o_cur_pc", lc4_pkg::RESET_PC, o_cur_pc);
            end else begin
                assert (o_cur_pc == prev_pc + (prev_hazard ? 16'd1 : 16'd2)) else
                    show_mismatch("o_cur_pc", prev_pc + (prev_hazard ? 16'd1 : 16'd2), o_cur_pc);
                if (o_cur_pc == prev_pc + 16'd1) begin
                    single_steps++;
                end
            end
            if (cyc < 3) begin
                assert (!o_wb_we_a && !o_wb_we_b) else begin
                    $display("write enable set at %0t before any instruction reached W", $time);
                    err_cnt++;
                end
            end
            check_write(o_wb_we_a, o_wb_wsel_a, o_wb_data_a, o_wb_pc_a, cyc, "a");
            check_write(o_wb_we_b, o_wb_wsel_b, o_wb_data_b, o_wb_pc_b, cyc, "b");
            // a dropped B is fetched again next cycle and overwrites its entry
            if (off >= 0 && off < PROG_MAX + 1) begin
                fetch_cycle[off] = cyc;
                fetch_cycle[off + 1] = cyc;
            end
            i_insn_a = fetch_word(o_cur_pc);
            i_insn_b = fetch_word(o_cur_pc + 16'd1);
            model_insn(i_insn_a, '0, '0, wr_a, rs_a, rt_a, dummy);
            model_insn(i_insn_b, '0, '0, wr_b, rs_b, rt_b, dummy);
            prev_hazard = wr_a && ((rs_b && i_insn_b[8:6] == i_insn_a[11:9]) ||
                                   (rt_b && i_insn_b[2:0] == i_insn_a[11:9]));
            prev_pc = o_cur_pc;
            if (off >= prog_len) begin
                drain++;
            end
            cyc++;
            @(negedge gwe);
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d expected writes never appeared", exp_q.size());
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = err_cnt;
        clear_program();
        add_insn(enc_const(3'd0, 9'd5));
        add_insn(enc_const(3'd1, 9'(-3)));
        add_insn(enc_const(3'd2, 9'd100));
        add_insn(enc_const(3'd3, 9'h100));
        run_program();
        report_test("reset", errs);
    endtask

    task automatic test_independent();
        int errs;
        errs = err_cnt;
        clear_program();
        add_insn(enc_const(3'd1, 9'd7));
        add_insn(enc_const(3'd2, 9'(-2)));
        add_insn(enc_const(3'd3, 9'h055));
        add_insn(enc_const(3'd4, 9'h0f0));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd5, 3'd1, 3'b000, 3'd2));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd6, 3'd3, 3'b010, 3'd4));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd7, 3'd1, 3'b011, 3'd3));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd0, 3'd2, 3'b010, 3'd4));
        add_insn(enc_rri(lc4_pkg::OP_ARITH, 3'd1, 3'd2, 5'(-5)));
        add_insn(enc_rri(lc4_pkg::OP_LOGIC, 3'd2, 3'd3, 5'h0c));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd3, 3'd4, 3'b000, 3'd6));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd4, 3'd5, 3'b010, 3'd7));
        run_program();
        assert (single_steps == 0) else begin
            $display("PC advanced by 1 in a program without pairing conflicts");
            err_cnt++;
        end
        report_test("independent", errs);
    endtask

    task automatic test_pair_dependency();
        int errs;
        errs = err_cnt;
        clear_program();
        add_insn(enc_const(3'd1, 9'd9));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd2, 3'd1, 3'b000, 3'd1));
        add_insn(enc_const(3'd3, 9'd4));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd4, 3'd2, 3'b011, 3'd3));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd5, 3'd4, 3'b010, 3'd1));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd6, 3'd5, 3'b010, 3'd4));
        run_program();
        assert (single_steps > 0) else begin
            $display("PC never advanced by 1 although B read A's destination");
            err_cnt++;
        end
        report_test("pair_dependency", errs);
    endtask

    task automatic test_chains();
        int errs;
        errs = err_cnt;
        clear_program();
        // both lanes write r1, then r2, in the same cycle
        add_insn(enc_const(3'd1, 9'd1));
        add_insn(enc_const(3'd1, 9'd2));
        add_insn(enc_rri(lc4_pkg::OP_ARITH, 3'd2, 3'd1, 5'd3));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd3, 3'd1, 3'b000, 3'd1));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd2, 3'd2, 3'b000, 3'd3));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd2, 3'd1, 3'b011, 3'd3));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd4, 3'd2, 3'b010, 3'd2));
        add_insn(enc_rrr(lc4_pkg::OP_LOGIC, 3'd5, 3'd2, 3'b000, 3'd3));
        add_insn(enc_rrr(lc4_pkg::OP_ARITH, 3'd6, 3'd4, 3'b010, 3'd5));
        add_insn(enc_rri(lc4_pkg::OP_ARITH, 3'd4, 3'd6, 5'(-1)));
        run_program();
        report_test("chains", errs);
    endtask

    task automatic test_random();
        int         errs;
        int         kind;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        errs = err_cnt;
        clear_program();
        for (int i = 0; i < LEN_RANDOM; i++) begin
            kind = $urandom_range(7, 0);
            rd = 3'($urandom);
            rs = 3'($urandom);
            rt = 3'($urandom);
            case (kind)
                0: add_insn(enc_const(rd, 9'($urandom)));
                1: add_insn(enc_rrr(lc4_pkg::OP_ARITH, rd, rs, 3'b000, rt));
                2: add_insn(enc_rrr(lc4_pkg::OP_ARITH, rd, rs, 3'b010, rt));
                3: add_insn(enc_rri(lc4_pkg::OP_ARITH, rd, rs, 5'($urandom)));
                4: add_insn(enc_rrr(lc4_pkg::OP_LOGIC, rd, rs, 3'b000, rt));
                5: add_insn(enc_rrr(lc4_pkg::OP_LOGIC, rd, rs, 3'b010, rt));
                6: add_insn(enc_rrr(lc4_pkg::OP_LOGIC, rd, rs, 3'b011, rt));
                default: add_insn(enc_rri(lc4_pkg::OP_LOGIC, rd, rs, 5'($urandom)));
            endcase
        end
        run_program();
        report_test("random", errs);
    endtask

    initial begin
        i_reset = 1'b1;
        i_insn_a = '0;
        i_insn_b = '0;
        void'($urandom(32'h36a4ff32));
        test_reset();
        test_independent();
        test_pair_dependency();
        test_chains();
        test_random();
        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* lc4_dual.f */
src/lc4_pkg.sv
src/issue_if.sv
src/wb_if.sv
src/issue_unit.sv
src/exec_lane.sv
src/regfile_2w.sv
src/lc4_dual_top.sv
+incdir+sim
sim/tb_lc4_dual.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lc4_dual
FILELIST  ?= lc4_dual.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
